/* rtl/busPkg.sv */
package busPkg;

  // A cache line is four 32-bit words moved as one INCR4 burst
  localparam int LINE_BEATS = 4;

  ////////////////////
  // AHB-Lite encodings
  ////////////////////

  typedef enum logic [1:0] {
    TRANS_IDLE   = 2'b00,
    TRANS_BUSY   = 2'b01,
    TRANS_NONSEQ = 2'b10,
    TRANS_SEQ    = 2'b11
  } htransT;

  // Only the two burst kinds the sequencers generate
  typedef enum logic [2:0] {
    BURST_SINGLE = 3'b000,
    BURST_INCR4  = 3'b011
  } hburstT;

  typedef enum logic [2:0] {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010
  } hsizeT;

  // Owner of the shared master port
  typedef enum logic [1:0] {IDLE, MEMREAD, MEMWRITE, INSTRREAD} busStateT;

  ////////////////////
  // Requests and beats
  ////////////////////

  typedef struct packed {
    logic [31:0] addr;
    logic        single;
  } fetchReqT;

  typedef struct packed {
    logic [31:0]                 addr;
    logic                        write;
    logic                        single;
    hsizeT                       size;
    logic [LINE_BEATS-1:0][31:0] wdata;
  } dataReqT;

  typedef struct packed {
    logic [LINE_BEATS-1:0][31:0] words;
  } lineRespT;

  // One address phase as offered by a sequencer
  typedef struct packed {
    logic [31:0] addr;
    htransT      trans;
    hburstT      burst;
    hsizeT       size;
    logic        write;
    logic [31:0] wdata;
  } beatReqT;

endpackage

/* rtl/lineSequencer.sv */
`timescale 1ns/100ps

module lineSequencer #(
  parameter type reqT = busPkg::fetchReqT
) (
  input  logic             clk,
  input  logic             rstN,
  // Requester side
  input  logic             strobe,
  input  reqT              req,
  output logic             busy,
  output logic             done,
  output busPkg::lineRespT line,
  // Arbiter side
  output logic             busRead,
  output logic             busWrite,
  output busPkg::beatReqT  beat,
  output logic             transComplete,
  input  logic             busInit,
  input  logic             busAck,
  input  logic [31:0]      readData
);

  import busPkg::*;

  // One extra bit so the address counter can show that every beat was issued
  localparam int CNT_W = $clog2(LINE_BEATS) + 1;

  reqT      reqQ;
  lineRespT lineBuf;

  logic             active;
  logic             isWrite;
  logic [CNT_W-1:0] addrCnt;
  logic [CNT_W-1:0] dataCnt;
  logic [CNT_W-1:0] numBeats;
  logic             addrPending;
  logic [CNT_W-2:0] addrIdx;

  logic                        reqWrite;
  hsizeT                       reqSize;
  logic [LINE_BEATS-1:0][31:0] reqWords;

  ////////////////////
  // Payload fields
  ////////////////////

  // Write flag, size and write words exist only in a load/store request
  generate
    if ($bits(reqT) > $bits(fetchReqT)) begin : gStorePayload
      dataReqT inReq;
      dataReqT heldReq;
      assign inReq    = dataReqT'(req);
      assign heldReq  = dataReqT'(reqQ);
      assign reqWrite = inReq.write;
      assign reqSize  = heldReq.size;
      assign reqWords = heldReq.wdata;
    end else begin : gFetchPayload
      // Instruction fetches are always word reads
      assign reqWrite = 1'b0;
      assign reqSize  = SIZE_WORD;
      assign reqWords = '0;
    end
  endgenerate

  ////////////////////
  // Beat counters
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      active  <= 1'b0;
      isWrite <= 1'b0;
      addrCnt <= '0;
      dataCnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= transComplete;
      if (strobe) begin
        active  <= 1'b1;
        isWrite <= reqWrite;
        addrCnt <= '0;
        dataCnt <= '0;
      end else begin
        // The address phase is taken on the grant cycle and on every ack after it
        if ((busInit || busAck) && addrPending) addrCnt <= addrCnt + 1'b1;
        if (active && busAck) dataCnt <= dataCnt + 1'b1;
        if (transComplete) active <= 1'b0;
      end
    end
  end

  // Request copy and read words carry no reset
  always_ff @(posedge clk) begin
    if (strobe) reqQ <= req;
    if (active && busAck && !isWrite) lineBuf.words[dataCnt[CNT_W-2:0]] <= readData;
  end

  assign numBeats    = reqQ.single ? CNT_W'(1) : CNT_W'(LINE_BEATS);
  assign addrPending = active && (addrCnt < numBeats);
  assign addrIdx     = addrCnt[CNT_W-2:0];

  ////////////////////
  // Beat generation
  ////////////////////

  always_comb begin
    beat.addr  = reqQ.addr + 32'({addrIdx, 2'b00});
    // First beat opens the burst and the rest continue it
    if (!addrPending) beat.trans = TRANS_IDLE;
    else if (addrCnt == '0) beat.trans = TRANS_NONSEQ;
    else beat.trans = TRANS_SEQ;
    beat.burst = reqQ.single ? BURST_SINGLE : BURST_INCR4;
    beat.size  = reqQ.single ? reqSize : SIZE_WORD;
    beat.write = isWrite;
    beat.wdata = reqWords[addrIdx];
  end

  // Last data phase of the run is acked in this cycle
  assign transComplete = active && busAck && (dataCnt == numBeats - 1'b1);

  assign busRead  = active && !isWrite;
  assign busWrite = active && isWrite;
  assign busy     = active;
  assign line     = lineBuf;

endmodule

/* rtl/ahbArbiter.sv */
`timescale 1ns/100ps

module ahbArbiter (
  input  logic            clk,
  input  logic            rstN,
  // Instruction fetch sequencer
  input  logic            ifuRead,
  input  busPkg::beatReqT ifuBeat,
  input  logic            ifuComplete,
  output logic            ifuInit,
  output logic            ifuAck,
  // Load/store sequencer
  input  logic            lsuRead,
  input  logic            lsuWrite,
  input  busPkg::beatReqT lsuBeat,
  input  logic            lsuComplete,
  output logic            lsuInit,
  output logic            lsuAck,
  output logic [31:0]     busReadData,
  // AHB-Lite master port
  input  logic [31:0]     HRDATA,
  input  logic            HREADY,
  output logic [31:0]     HADDR,
  output logic [31:0]     HWDATA,
  output logic            HWRITE,
  output busPkg::hsizeT   HSIZE,
  output busPkg::hburstT  HBURST,
  output busPkg::htransT  HTRANS,
  output logic [3:0]      HPROT,
  // Data-phase copies of the address phase for byte lanes
  output logic [1:0]      HADDRD,
  output busPkg::hsizeT   HSIZED,
  output logic            HWRITED
);

  import busPkg::*;

  busStateT busState;
  busStateT nextBusState;
  logic     grantData;
  logic     granted;
  beatReqT  grantBeat;

  ////////////////////
  // Grant decision
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busState <= IDLE;
    end else begin
      busState <= nextBusState;
    end
  end

  // Data goes before instructions, but an owner keeps the bus until its
  // last beat completes and the waiting side then takes over directly
  always_comb begin
    case (busState)
      IDLE: begin
        if (lsuRead) nextBusState = MEMREAD;
        else if (lsuWrite) nextBusState = MEMWRITE;
        else if (ifuRead) nextBusState = INSTRREAD;
        else nextBusState = IDLE;
      end
      MEMREAD, MEMWRITE: begin
        if (lsuComplete && ifuRead) nextBusState = INSTRREAD;
        else if (lsuComplete) nextBusState = IDLE;
        else nextBusState = busState;
      end
      INSTRREAD: begin
        if (ifuComplete && lsuRead) nextBusState = MEMREAD;
        else if (ifuComplete && lsuWrite) nextBusState = MEMWRITE;
        else if (ifuComplete) nextBusState = IDLE;
        else nextBusState = INSTRREAD;
      end
      default: nextBusState = IDLE;
    endcase
  end

  ////////////////////
  // Address phase
  ////////////////////

  // The next owner drives the address phase, so a new grant starts at once
  assign grantData = (nextBusState == MEMREAD) || (nextBusState == MEMWRITE);
  assign granted   = (nextBusState != IDLE);
  assign grantBeat = grantData ? lsuBeat : ifuBeat;

  assign HADDR  = grantBeat.addr;
  assign HTRANS = granted ? grantBeat.trans : TRANS_IDLE;
  assign HBURST = grantBeat.burst;
  assign HSIZE  = grantBeat.size;
  assign HWRITE = granted && grantBeat.write;
  // Privileged data access for every transfer
  assign HPROT  = 4'b0011;

  ////////////////////
  // Data phase
  ////////////////////

  // Write data follows its address phase by one accepted cycle
  always_ff @(posedge clk) begin
    if (lsuInit || lsuAck) HWDATA <= lsuBeat.wdata;
  end

  // Only an accepted address phase moves into the data phase
  always_ff @(posedge clk) begin
    if (HREADY) begin
      HADDRD <= HADDR[1:0];
      HSIZED <= HSIZE;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      HWRITED <= 1'b0;
    end else if (HREADY) begin
      HWRITED <= HWRITE;
    end
  end

  ////////////////////
  // Result routing
  ////////////////////

  assign busReadData = HRDATA;

  // Init marks the first cycle of a grant and ack belongs to the current owner
  assign ifuInit = (busState != INSTRREAD) && (nextBusState == INSTRREAD);
  assign lsuInit = ((busState != MEMREAD) && (nextBusState == MEMREAD)) ||
                   ((busState != MEMWRITE) && (nextBusState == MEMWRITE));
  assign ifuAck  = HREADY && (busState == INSTRREAD);
  assign lsuAck  = HREADY && ((busState == MEMREAD) || (busState == MEMWRITE));

endmodule

/* rtl/ahbSram.sv */
`timescale 1ns/100ps

module ahbSram #(
  parameter int WAIT_STATES = 1,
  parameter int DEPTH_WORDS = 1024
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic [31:0]    HADDR,
  input  busPkg::htransT HTRANS,
  input  logic           HWRITE,
  input  busPkg::hsizeT  HSIZE,
  input  logic [31:0]    HWDATA,
  output logic [31:0]    HRDATA,
  output logic           HREADY
);

  import busPkg::*;

  localparam int IDX_W = $clog2(DEPTH_WORDS);
  // Keep the counter one bit wide even with no wait states
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [31:0] mem [DEPTH_WORDS];

  // Captured address phase of the beat now in its data phase
  logic             pendValid;
  logic             pendWrite;
  hsizeT            pendSize;
  logic [IDX_W+1:0] pendAddr;
  logic [IDX_W-1:0] pendIdx;
  logic [CNT_W-1:0] waitCnt;
  logic [3:0]       byteEn;
  logic             activeTrans;

  assign activeTrans = (HTRANS == TRANS_NONSEQ) || (HTRANS == TRANS_SEQ);

  ////////////////////
  // Address capture
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pendValid <= 1'b0;
      waitCnt   <= '0;
    end else if (HREADY) begin
      // A new data phase starts with the full wait count
      pendValid <= activeTrans;
      waitCnt   <= CNT_W'(WAIT_STATES);
    end else begin
      waitCnt <= waitCnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (HREADY) begin
      pendWrite <= HWRITE;
      pendSize  <= HSIZE;
      pendAddr  <= HADDR[IDX_W+1:0];
    end
  end

  // The data phase stalls until the wait count runs out
  assign HREADY  = !(pendValid && (waitCnt != '0));
  assign pendIdx = pendAddr[IDX_W+1:2];

  ////////////////////
  // Storage
  ////////////////////

  // Little-endian lanes picked by size and the low address bits
  always_comb begin
    case (pendSize)
      SIZE_BYTE: byteEn = 4'b0001 << pendAddr[1:0];
      SIZE_HALF: byteEn = pendAddr[1] ? 4'b1100 : 4'b0011;
      default:   byteEn = 4'b1111;
    endcase
  end

  always_ff @(posedge clk) begin
    if (HREADY && pendValid && pendWrite) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byteEn[lane]) mem[pendIdx][8*lane +: 8] <= HWDATA[8*lane +: 8];
      end
    end
  end

  // Read word is valid in the cycle HREADY closes a read data phase
  assign HRDATA = mem[pendIdx];

endmodule

/* rtl/busSubsystem.sv */
`timescale 1ns/100ps

module busSubsystem #(
  parameter int WAIT_STATES = 1
) (
  input  logic             clk,
  input  logic             rstN,
  // Instruction fetch requester
  input  logic             fetchStrobe,
  input  busPkg::fetchReqT fetchReq,
  output logic             fetchBusy,
  output logic             fetchDone,
  output busPkg::lineRespT fetchLine,
  // Load/store requester
  input  logic             dataStrobe,
  input  busPkg::dataReqT  dataReq,
  output logic             dataBusy,
  output logic             dataDone,
  output busPkg::lineRespT dataLine,
  // Bus observation
  output busPkg::htransT   HTRANS,
  output logic [31:0]      HADDR
);

  import busPkg::*;

  localparam int MEM_WORDS = 1024;

  logic        fetchRead, fetchInit, fetchAck, fetchComplete;
  logic        dataRead, dataWrite, dataInit, dataAck, dataComplete;
  beatReqT     fetchBeat;
  beatReqT     dataBeat;
  logic [31:0] busReadData;

  logic [31:0] HRDATA, HWDATA;
  logic        HREADY, HWRITE;
  hsizeT       HSIZE;

  ////////////////////
  // Sequencers
  ////////////////////

  // A fetch never writes, so its write request stays open
  lineSequencer #(.reqT(fetchReqT)) fetchSeq (
    .clk(clk), .rstN(rstN), .strobe(fetchStrobe), .req(fetchReq),
    .busy(fetchBusy), .done(fetchDone), .line(fetchLine),
    .busRead(fetchRead), .busWrite(), .beat(fetchBeat),
    .transComplete(fetchComplete), .busInit(fetchInit), .busAck(fetchAck),
    .readData(busReadData)
  );

  lineSequencer #(.reqT(dataReqT)) dataSeq (
    .clk(clk), .rstN(rstN), .strobe(dataStrobe), .req(dataReq),
    .busy(dataBusy), .done(dataDone), .line(dataLine),
    .busRead(dataRead), .busWrite(dataWrite), .beat(dataBeat),
    .transComplete(dataComplete), .busInit(dataInit), .busAck(dataAck),
    .readData(busReadData)
  );

  ////////////////////
  // Arbiter and memory
  ////////////////////

  // The slave keeps its own copy of the address phase, so burst, protection
  // and the delayed subword signals have no load here
  ahbArbiter arb (
    .clk(clk), .rstN(rstN),
    .ifuRead(fetchRead), .ifuBeat(fetchBeat), .ifuComplete(fetchComplete),
    .ifuInit(fetchInit), .ifuAck(fetchAck),
    .lsuRead(dataRead), .lsuWrite(dataWrite), .lsuBeat(dataBeat),
    .lsuComplete(dataComplete), .lsuInit(dataInit), .lsuAck(dataAck),
    .busReadData(busReadData), .HRDATA(HRDATA), .HREADY(HREADY),
    .HADDR(HADDR), .HWDATA(HWDATA), .HWRITE(HWRITE), .HSIZE(HSIZE),
    .HBURST(), .HTRANS(HTRANS), .HPROT(),
    .HADDRD(), .HSIZED(), .HWRITED()
  );

  ahbSram #(.WAIT_STATES(WAIT_STATES), .DEPTH_WORDS(MEM_WORDS)) sram (
    .clk(clk), .rstN(rstN), .HADDR(HADDR), .HTRANS(HTRANS), .HWRITE(HWRITE),
    .HSIZE(HSIZE), .HWDATA(HWDATA), .HRDATA(HRDATA), .HREADY(HREADY)
  );

endmodule

/* tests/busTasks.svh */
`ifndef BUS_TASKS_SVH
`define BUS_TASKS_SVH

// Failed checks over the whole run
int errorCount = 0;

logic [31:0] randState = 32'hfde29e6c;

// Expected memory contents, one entry per SRAM word
logic [31:0] shadowMem [1024];

task automatic checkValue(input string what, input logic [31:0] got,
                          input logic [31:0] expected);
  if (got !== expected) begin
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    errorCount++;
  end
endtask

// Xorshift generator with the 13, 17, 5 shift triple
function automatic logic [31:0] nextRandom();
  randState = randState ^ (randState << 13);
  randState = randState ^ (randState >> 17);
  randState = randState ^ (randState << 5);
  return randState;
endfunction

// A transfer of 2**size bytes changes the lanes from its low address bits upward
task automatic shadowWrite(input logic [31:0] addr, input hsizeT size,
                           input logic [31:0] data);
  int first;
  int count;
  first = int'(addr[1:0]);
  count = 1 << int'(size);
  for (int lane = first; lane < first + count; lane++) begin
    shadowMem[addr[11:2]][8*lane +: 8] = data[8*lane +: 8];
  end
endtask

task automatic shadowStoreLine(input logic [31:0] addr, input lineRespT wr);
  for (int i = 0; i < LINE_BEATS; i++) begin
    shadowMem[addr[11:2] + 10'(i)] = wr.words[i];
  end
endtask

// Word i of a line sits four bytes above word i-1
function automatic lineRespT shadowLine(input logic [31:0] addr);
  lineRespT expected;
  for (int i = 0; i < LINE_BEATS; i++) begin
    expected.words[i] = shadowMem[addr[11:2] + 10'(i)];
  end
  return expected;
endfunction

`endif

/* tests/busTb.sv */
`timescale 1ns/100ps

module busTb;

  import busPkg::*;

  localparam int WAIT_STATES  = 1;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES  = 20;
  // Strobe to done without contention, for a line and for one beat
  localparam int LINE_LATENCY = LINE_BEATS * (1 + WAIT_STATES) + 2;
  localparam int BEAT_LATENCY = 1 + WAIT_STATES + 2;
  // A line may wait behind a whole line of the other requester
  localparam int WORST_LATENCY   = 2 * LINE_LATENCY;
  localparam int NUM_TRANSFERS   = 12;
  localparam int WATCHDOG_CYCLES =
    2 * (RESET_CYCLES + IDLE_CYCLES + NUM_TRANSFERS * (WORST_LATENCY + 3));
  localparam logic [31:0] LINE_A = 32'h100;
  localparam logic [31:0] LINE_B = 32'h200;
  localparam logic [31:0] LINE_C = 32'h300;

  logic        clk;
  logic        rstN;
  logic        fetchStrobe;
  fetchReqT    fetchReq;
  logic        fetchBusy;
  logic        fetchDone;
  lineRespT    fetchLine;
  logic        dataStrobe;
  dataReqT     dataReq;
  logic        dataBusy;
  logic        dataDone;
  lineRespT    dataLine;
  htransT      HTRANS;
  logic [31:0] HADDR;

  int testCount   = 0;
  int failedTests = 0;

  // Bus history, sampled on falling edges where every output is settled
  int          cycleCnt       = 0;
  int          fetchDoneCount = 0;
  int          dataDoneCount  = 0;
  int          nonseqCount    = 0;
  int          busBusyCount   = 0;
  int          fetchStrobeCycle;
  int          fetchDoneCycle;
  int          dataStrobeCycle;
  int          dataDoneCycle;
  lineRespT    fetchLineSeen;
  lineRespT    dataLineSeen;
  // Address of every NONSEQ beat in the order it appeared
  logic [31:0] nonseqAddr [$];

  `include "busTasks.svh"

  busSubsystem #(.WAIT_STATES(WAIT_STATES)) UUT (
    .clk(clk), .rstN(rstN),
    .fetchStrobe(fetchStrobe), .fetchReq(fetchReq), .fetchBusy(fetchBusy),
    .fetchDone(fetchDone), .fetchLine(fetchLine),
    .dataStrobe(dataStrobe), .dataReq(dataReq), .dataBusy(dataBusy),
    .dataDone(dataDone), .dataLine(dataLine),
    .HTRANS(HTRANS), .HADDR(HADDR)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycleCnt <= cycleCnt + 1;

  always @(negedge clk) begin
    if (fetchStrobe) fetchStrobeCycle = cycleCnt;
    if (dataStrobe) dataStrobeCycle = cycleCnt;
    if (fetchDone) begin
      fetchDoneCycle = cycleCnt;
      fetchLineSeen  = fetchLine;
      fetchDoneCount++;
    end
    if (dataDone) begin
      dataDoneCycle = cycleCnt;
      dataLineSeen  = dataLine;
      dataDoneCount++;
    end
    if (HTRANS == TRANS_NONSEQ) begin
      nonseqCount++;
      nonseqAddr.push_back(HADDR);
    end
    if (HTRANS != TRANS_IDLE) busBusyCount++;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("The run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  ////////////////////
  // Request helpers
  ////////////////////

  function automatic dataReqT makeData(input logic [31:0] addr, input logic write,
                                       input logic single, input hsizeT size,
                                       input lineRespT wr);
    dataReqT d;
    d.addr   = addr;
    d.write  = write;
    d.single = single;
    d.size   = size;
    d.wdata  = wr.words;
    return d;
  endfunction

  function automatic fetchReqT makeFetch(input logic [31:0] addr);
    fetchReqT f;
    f.addr   = addr;
    f.single = 1'b0;
    return f;
  endfunction

  // Strobes last one cycle, so two calls in a row start two cycles apart
  task automatic issue(input logic doFetch, input fetchReqT f, input logic doData,
                       input dataReqT d);
    @(posedge clk);
    if (doFetch) fetchReq <= f;
    if (doData) dataReq <= d;
    fetchStrobe <= doFetch;
    dataStrobe  <= doData;
    @(posedge clk);
    fetchStrobe <= 1'b0;
    dataStrobe  <= 1'b0;
  endtask

  task automatic waitDone(input logic onFetch, input int start);
    int waited;
    waited = 0;
    while ((onFetch ? fetchDoneCount : dataDoneCount) == start &&
           waited < WORST_LATENCY + 4) begin
      @(posedge clk);
      waited++;
    end
    if ((onFetch ? fetchDoneCount : dataDoneCount) == start) begin
      if (onFetch) $display("Timed out at %0t ns waiting for fetchDone", $time);
      else $display("Timed out at %0t ns waiting for dataDone", $time);
      errorCount++;
    end
  endtask

  // The requester turns busy in the cycle after its strobe
  task automatic dataRun(input dataReqT d);
    int start;
    start = dataDoneCount;
    issue(1'b0, '0, 1'b1, d);
    @(negedge clk);
    checkValue("dataBusy after strobe", 32'(dataBusy), 32'd1);
    waitDone(1'b0, start);
  endtask

  task automatic checkLine(input string what, input lineRespT got, input logic [31:0] addr);
    lineRespT expected;
    expected = shadowLine(addr);
    for (int i = 0; i < LINE_BEATS; i++) begin
      checkValue($sformatf("%s word %0d", what, i), got.words[i], expected.words[i]);
    end
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    testCount++;
    if (errorCount == errsBefore) begin
      $display("PASS %s", name);
    end else begin
      failedTests++;
      $display("FAIL %s", name);
    end
  endtask

  // Random line written into memory through the load/store side
  task automatic writeRandomLine(input logic [31:0] addr);
    lineRespT wr;
    for (int i = 0; i < LINE_BEATS; i++) wr.words[i] = nextRandom();
    shadowStoreLine(addr, wr);
    dataRun(makeData(addr, 1'b1, 1'b0, SIZE_WORD, wr));
    checkValue("line write latency", dataDoneCycle - dataStrobeCycle, LINE_LATENCY);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic testIdleAfterReset();
    int errs;
    int doneStart;
    int busStart;
    errs      = errorCount;
    doneStart = fetchDoneCount + dataDoneCount;
    busStart  = busBusyCount;
    repeat (IDLE_CYCLES) @(posedge clk);
    checkValue("non-idle HTRANS cycles", busBusyCount - busStart, 0);
    checkValue("done strobes while idle", fetchDoneCount + dataDoneCount - doneStart, 0);
    finishTest("idle bus after reset", errs);
  endtask

  task automatic testLineWriteRead();
    int errs;
    errs = errorCount;
    writeRandomLine(LINE_A);
    dataRun(makeData(LINE_A, 1'b0, 1'b0, SIZE_WORD, '0));
    checkValue("line read latency", dataDoneCycle - dataStrobeCycle, LINE_LATENCY);
    checkLine("dataLine", dataLineSeen, LINE_A);
    @(negedge clk);
    checkValue("dataBusy after done", 32'(dataBusy), 32'd0);
    finishTest("line write then line read", errs);
  endtask

  task automatic testSubwordWrite();
    lineRespT    sub;
    logic [31:0] value;
    int          errs;
    errs = errorCount;
    writeRandomLine(LINE_B);
    // The slave takes subword data from the lanes that match the address
    sub   = '0;
    value = nextRandom();
    sub.words[0] = {4{value[7:0]}};
    shadowWrite(LINE_B + 32'h5, SIZE_BYTE, sub.words[0]);
    dataRun(makeData(LINE_B + 32'h5, 1'b1, 1'b1, SIZE_BYTE, sub));
    checkValue("byte write latency", dataDoneCycle - dataStrobeCycle, BEAT_LATENCY);
    value = nextRandom();
    sub.words[0] = {2{value[15:0]}};
    shadowWrite(LINE_B + 32'ha, SIZE_HALF, sub.words[0]);
    dataRun(makeData(LINE_B + 32'ha, 1'b1, 1'b1, SIZE_HALF, sub));
    dataRun(makeData(LINE_B, 1'b0, 1'b0, SIZE_WORD, '0));
    checkLine("dataLine after subword writes", dataLineSeen, LINE_B);
    finishTest("byte and halfword writes", errs);
  endtask

  task automatic testFetchRead();
    int errs;
    int start;
    errs = errorCount;
    writeRandomLine(LINE_C);
    @(negedge clk);
    checkValue("fetchBusy before strobe", 32'(fetchBusy), 32'd0);
    start = fetchDoneCount;
    issue(1'b1, makeFetch(LINE_C), 1'b0, '0);
    waitDone(1'b1, start);
    checkValue("fetch latency", fetchDoneCycle - fetchStrobeCycle, LINE_LATENCY);
    checkLine("fetchLine", fetchLineSeen, LINE_C);
    @(negedge clk);
    checkValue("fetchBusy after done", 32'(fetchBusy), 32'd0);
    finishTest("fetch line read", errs);
  endtask

  task automatic testSameCycle();
    int errs;
    int fetchStart;
    int dataStart;
    errs       = errorCount;
    fetchStart = fetchDoneCount;
    dataStart  = dataDoneCount;
    issue(1'b1, makeFetch(LINE_B), 1'b1, makeData(LINE_A, 1'b0, 1'b0, SIZE_WORD, '0));
    waitDone(1'b0, dataStart);
    waitDone(1'b1, fetchStart);
    checkValue("dataDone before fetchDone", 32'(dataDoneCycle < fetchDoneCycle), 32'd1);
    checkLine("dataLine", dataLineSeen, LINE_A);
    checkLine("fetchLine", fetchLineSeen, LINE_B);
    finishTest("same-cycle requests favour data", errs);
  endtask

  task automatic testGrantKept();
    int errs;
    int fetchStart;
    int dataStart;
    int nonseqStart;
    errs        = errorCount;
    fetchStart  = fetchDoneCount;
    dataStart   = dataDoneCount;
    nonseqStart = nonseqCount;
    issue(1'b1, makeFetch(LINE_A), 1'b0, '0);
    issue(1'b0, '0, 1'b1, makeData(LINE_B, 1'b0, 1'b0, SIZE_WORD, '0));
    waitDone(1'b1, fetchStart);
    waitDone(1'b0, dataStart);
    checkValue("fetchDone before dataDone", 32'(fetchDoneCycle < dataDoneCycle), 32'd1);
    checkValue("NONSEQ cycles", nonseqCount - nonseqStart, 2);
    // The fetch line opens the bus and the load line follows it
    checkValue("first NONSEQ HADDR", nonseqAddr[nonseqStart], LINE_A);
    checkValue("second NONSEQ HADDR", nonseqAddr[nonseqStart + 1], LINE_B);
    checkLine("fetchLine", fetchLineSeen, LINE_A);
    checkLine("dataLine", dataLineSeen, LINE_B);
    finishTest("fetch in progress keeps the bus", errs);
  endtask

  initial begin
    rstN        <= 1'b0;
    fetchStrobe <= 1'b0;
    fetchReq    <= '0;
    dataStrobe  <= 1'b0;
    dataReq     <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstN <= 1'b1;
    testIdleAfterReset();
    testLineWriteRead();
    testSubwordWrite();
    testFetchRead();
    testSameCycle();
    testGrantKept();
    @(posedge clk);
    $display("%0d tests run, %0d failed, %0d check errors", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+tests
rtl/busPkg.sv
rtl/lineSequencer.sv
rtl/ahbArbiter.sv
rtl/ahbSram.sv
rtl/busSubsystem.sv
tests/busTb.sv

/* run.sh */
#!/bin/sh
# Build and run the bus subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module busTb \
  -f filelist.f -o busSim

./obj_dir/busSim | tee sim.log

# The run passes only if the testbench printed its pass message
grep -q "All tests passed!" sim.log
echo "Simulation passed"
